/* dv/tb_quad_root.sv */
`timescale 1ns/10ps

module tb_quad_root;

    import quad_root_pkg::*;

    localparam int N_DIRECTED = 8;
    localparam int N_RANDOM = 300;
    localparam int N_BURST = 40;
    localparam int N_SAMPLES = N_DIRECTED + N_RANDOM + N_BURST;
    localparam int WATCHDOG_CYCLES = N_SAMPLES * 16 + 200;

    logic      clk;
    logic      arst_n;
    coef_in_t  din;
    logic      din_valid;
    logic      fifo_full;
    root_res_t dout;
    logic      dout_valid;

    logic [31:0] lcg_state = 32'd34193;
    root_res_t   expect_q[$];
    int          sent_count = 0;
    int          recv_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    logic        saw_full = 1'b0;

    quad_root_iterative dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .din       (din),
        .din_valid (din_valid),
        .fifo_full (fifo_full),
        .dout      (dout),
        .dout_valid(dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper half of the lcg word since the low bits cycle too fast
    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = next_rand();
        return r[31:16];
    endfunction

    function automatic longint clamp_sqrt_range(input longint v);
        if (v > 511) begin
            return 511;
        end else if (v < -512) begin
            return -512;
        end
        return v;
    endfunction

    function automatic longint floor_sqrt(input longint n);
        longint r;
        r = 0;
        while ((r + 1) * (r + 1) <= n) begin
            r++;
        end
        return r;
    endfunction

    // reference model of the whole chain
    function automatic root_res_t expected_result(input coef_in_t s);
        root_res_t r;
        longint    d;
        longint    dq;
        longint    bq;
        longint    sq;
        longint    sum_p;
        longint    sum_m;
        // b^2 and 4c both at point 28
        d = longint'(s.b) * longint'(s.b) - 4 * (longint'(s.c) <<< 14);
        dq = clamp_sqrt_range(d >>> 21);
        bq = clamp_sqrt_range(longint'(s.b) >>> 7);
        r.band = s.band;
        if (dq < 0) begin
            r.error = 1'b1;
            r.x1 = '0;
            r.x2 = '0;
        end else begin
            sq = floor_sqrt(dq * 128);
            sum_p = -bq + sq;
            sum_m = -bq - sq;
            r.error = 1'b0;
            r.x1 = root_t'(sum_p >>> 1);
            r.x2 = root_t'(sum_m >>> 1);
        end
        return r;
    endfunction

    function automatic coef_in_t make_sample(input logic [15:0] b, input logic [15:0] c,
                                             input logic [1:0] band);
        coef_in_t s;
        s.b = b;
        s.c = c;
        s.band = band;
        return s;
    endfunction

    function automatic coef_in_t random_sample();
        coef_in_t    s;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] sel;
        b = rand16();
        c = rand16();
        sel = rand16();
        s.band = sel[15:14];
        case (sel[13:12])
            2'd0: begin
                s.b = b;
                s.c = c;
            end
            2'd1: begin
                // small coefficients keep the discriminant inside the cast range
                s.b = coef_t'($signed(b) >>> 1);
                s.c = coef_t'($signed(c) >>> 4);
            end
            2'd2: begin
                // c well above b^2/4
                s.b = coef_t'($signed(b) >>> 3);
                s.c = {1'b0, c[14:0]} | 16'h1000;
            end
            default: begin
                // b near +-2 with c strongly negative drives the discriminant into saturation
                s.b = sel[11] ? (16'h7fff - {8'd0, b[7:0]}) : (16'h8000 + {8'd0, b[7:0]});
                s.c = 16'h8000 | {8'd0, c[7:0]};
            end
        endcase
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // waits for room in the fifo and then drives one valid cycle
    task automatic send_sample(input coef_in_t s);
        @(negedge clk);
        while (fifo_full) begin
            saw_full = 1'b1;
            @(posedge clk);
            din_valid <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        din <= s;
        din_valid <= 1'b1;
        expect_q.push_back(expected_result(s));
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        din_valid <= 1'b0;
    endtask

    always @(negedge clk) begin : monitor
        root_res_t exp_res;
        if (arst_n && dout_valid) begin
            recv_count++;
            if (expect_q.size() == 0) begin
                error_count++;
                $display("a result arrived with no sample pending, band %0d", dout.band);
            end else begin
                exp_res = expect_q.pop_front();
                check_value("dout.x1", {22'd0, dout.x1}, {22'd0, exp_res.x1});
                check_value("dout.x2", {22'd0, dout.x2}, {22'd0, exp_res.x2});
                check_value("dout.error", {31'd0, dout.error}, {31'd0, exp_res.error});
                check_value("dout.band", {30'd0, dout.band}, {30'd0, exp_res.band});
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("the results did not arrive in time, %0d of %0d received",
                 recv_count, sent_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [15:0] gap;
        arst_n <= 1'b0;
        din <= '0;
        din_valid <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("dout_valid", {31'd0, dout_valid}, 32'd0);
        check_value("fifo_full", {31'd0, fifo_full}, 32'd0);

        // negative, zero, clamped and exact discriminants
        send_sample(make_sample(16'h0000, 16'h2000, 2'd1));
        send_sample(make_sample(16'h4000, 16'h1000, 2'd2));
        send_sample(make_sample(16'h7fff, 16'h8000, 2'd3));
        send_sample(make_sample(16'h8000, 16'h8000, 2'd0));
        send_sample(make_sample(16'h1000, 16'h7fff, 2'd3));
        send_sample(make_sample(16'hc000, 16'hf000, 2'd1));
        send_sample(make_sample(16'h0123, 16'h0456, 2'd2));
        send_sample(make_sample(16'h2000, 16'h0000, 2'd0));
        idle_cycle();

        for (int i = 0; i < N_RANDOM; i++) begin
            gap = rand16();
            if (gap[15]) begin
                repeat (gap[14:13] + 1) idle_cycle();
            end
            send_sample(random_sample());
        end
        idle_cycle();

        // back to back until the early full flag holds us off
        saw_full = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            send_sample(random_sample());
        end
        idle_cycle();

        while (recv_count < sent_count) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        if (!saw_full) begin
            error_count++;
            $display("fifo_full never rose during the burst");
        end
        if (expect_q.size() != 0) begin
            error_count++;
            $display("%0d expected results are still waiting", expect_q.size());
        end
        if (recv_count != sent_count) begin
            error_count++;
            $display("%0d samples were accepted but %0d results came out",
                     sent_count, recv_count);
        end

        $display("samples %0d, results %0d, checks %0d, errors %0d",
                 sent_count, recv_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/quad_root_pkg.sv
hw/fixed_cast.sv
hw/disc_frontend.sv
hw/root_fifo.sv
hw/iterative_sqrt.sv
hw/root_solver.sv
hw/quad_root_iterative.sv
dv/tb_quad_root.sv

/* hw/disc_frontend.sv */
`timescale 1ns/10ps

module disc_frontend (
    input  logic                     clk,
    input  logic                     arst_n,
    input  quad_root_pkg::coef_in_t  din,
    input  logic                     din_valid,
    output quad_root_pkg::root_req_t req,
    output logic                     req_valid
);

    import quad_root_pkg::*;

    // stage 1, b^2 and c both at point 28
    disc_t b_sq_s1;
    disc_t c_s1;
    coef_t b_s1;
    band_t band_s1;
    logic  valid_s1;

    // stage 2, the discriminant
    disc_t disc_s2;
    coef_t b_s2;
    band_t band_s2;
    logic  valid_s2;

    // stage 3, the casts
    sqrt_t disc_cast;
    sqrt_t b_cast;
    band_t band_s3;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            valid_s1 <= din_valid;
            valid_s2 <= valid_s1;
            req_valid <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        b_sq_s1 <= disc_t'(din.b) * disc_t'(din.b);
        c_s1 <= disc_t'(din.c) <<< (DISC_POINT - DIN_POINT);
        b_s1 <= din.b;
        band_s1 <= din.band;

        // 4c is two more bits up
        disc_s2 <= b_sq_s1 - (c_s1 <<< 2);
        b_s2 <= b_s1;
        band_s2 <= band_s1;

        band_s3 <= band_s2;
    end

    fixed_cast #(
        .DIN_WIDTH (DISC_WIDTH),
        .DIN_POINT (DISC_POINT),
        .DOUT_WIDTH(SQRT_WIDTH),
        .DOUT_POINT(SQRT_POINT)
    ) disc_cast0 (
        .clk   (clk),
        .arst_n(arst_n),
        .din   (disc_s2),
        .dout  (disc_cast)
    );

    // b was held one extra stage to line up with the discriminant
    fixed_cast #(
        .DIN_WIDTH (DIN_WIDTH),
        .DIN_POINT (DIN_POINT),
        .DOUT_WIDTH(SQRT_WIDTH),
        .DOUT_POINT(SQRT_POINT)
    ) b_cast0 (
        .clk   (clk),
        .arst_n(arst_n),
        .din   (b_s2),
        .dout  (b_cast)
    );

    assign req.disc = disc_cast;
    assign req.b_q = b_cast;
    assign req.band = band_s3;

endmodule

/* hw/fixed_cast.sv */
`timescale 1ns/10ps

module fixed_cast #(
    parameter int DIN_WIDTH = 16,
    parameter int DIN_POINT = 14,
    parameter int DOUT_WIDTH = 10,
    parameter int DOUT_POINT = 7
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic signed [DIN_WIDTH-1:0]  din,
    output logic signed [DOUT_WIDTH-1:0] dout
);

    localparam int SHIFT = DIN_POINT - DOUT_POINT;
    localparam int GROW = (SHIFT < 0) ? -SHIFT : 0;
    localparam int CMP_WIDTH =
        ((DIN_WIDTH + GROW > DOUT_WIDTH) ? DIN_WIDTH + GROW : DOUT_WIDTH) + 1;

    // largest and smallest value the output can hold
    localparam logic signed [CMP_WIDTH-1:0] MAX_VAL =
        {{(CMP_WIDTH - DOUT_WIDTH + 1){1'b0}}, {(DOUT_WIDTH - 1){1'b1}}};
    localparam logic signed [CMP_WIDTH-1:0] MIN_VAL = ~MAX_VAL;

    logic signed [CMP_WIDTH-1:0] aligned;

    generate
        if (SHIFT >= 0) begin : g_drop_frac
            // arithmetic shift floors toward minus infinity
            assign aligned = CMP_WIDTH'(din) >>> SHIFT;
        end else begin : g_add_frac
            assign aligned = CMP_WIDTH'(din) <<< GROW;
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else if (aligned > MAX_VAL) begin
            dout <= MAX_VAL[DOUT_WIDTH-1:0];
        end else if (aligned < MIN_VAL) begin
            dout <= MIN_VAL[DOUT_WIDTH-1:0];
        end else begin
            dout <= aligned[DOUT_WIDTH-1:0];
        end
    end

endmodule

/* hw/iterative_sqrt.sv */
`timescale 1ns/10ps

module iterative_sqrt (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic [quad_root_pkg::SQRT_WIDTH-1:0] radicand,
    output logic                               busy,
    output logic                               done,
    output logic [quad_root_pkg::SQRT_WIDTH-1:0] root
);

    import quad_root_pkg::*;

    // radicand with its zero fraction bits, consumed two bits per cycle
    logic [2*SQRT_ITER-1:0] rad_sh;
    logic [SQRT_ITER:0]     rem;
    logic [SQRT_ITER-1:0]   q;
    logic [3:0]             cnt;

    logic [SQRT_ITER+2:0]   rem_shift;
    logic [SQRT_ITER+2:0]   trial;
    logic                   fits;

    assign rem_shift = {rem, rad_sh[2*SQRT_ITER-1 -: 2]};
    assign trial = {1'b0, q, 2'b01};
    assign fits = (rem_shift >= trial);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                cnt <= 4'(SQRT_ITER - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            rad_sh <= (2 * SQRT_ITER)'(radicand) << SQRT_POINT;
            rem <= '0;
            q <= '0;
        end else if (busy) begin
            rad_sh <= rad_sh << 2;
            // restoring step, keep the subtraction only if it fits
            if (fits) begin
                rem <= (SQRT_ITER + 1)'(rem_shift - trial);
                q <= {q[SQRT_ITER-2:0], 1'b1};
            end else begin
                rem <= (SQRT_ITER + 1)'(rem_shift);
                q <= {q[SQRT_ITER-2:0], 1'b0};
            end
        end
    end

    assign root = SQRT_WIDTH'(q);

endmodule

/* hw/quad_root_iterative.sv */
`timescale 1ns/10ps

module quad_root_iterative (
    input  logic                     clk,
    input  logic                     arst_n,
    input  quad_root_pkg::coef_in_t  din,
    input  logic                     din_valid,
    output logic                     fifo_full,
    output quad_root_pkg::root_res_t dout,
    output logic                     dout_valid
);

    import quad_root_pkg::*;

    root_req_t req;
    logic      req_valid;
    root_req_t head;
    logic      not_empty;
    logic      pop;

    disc_frontend frontend0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .din      (din),
        .din_valid(din_valid),
        .req      (req),
        .req_valid(req_valid)
    );

    // absorbs the rate gap between the pipeline and the serial root
    root_fifo fifo0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_data  (req),
        .wr_en    (req_valid),
        .head     (head),
        .not_empty(not_empty),
        .pop      (pop),
        .fifo_full(fifo_full)
    );

    root_solver solver0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .dout      (dout),
        .dout_valid(dout_valid)
    );

endmodule

/* hw/quad_root_pkg.sv */
package quad_root_pkg;

    // coefficient format, Q1.14
    localparam int DIN_WIDTH = 16;
    localparam int DIN_POINT = 14;

    // square-root domain format
    localparam int SQRT_WIDTH = 10;
    localparam int SQRT_POINT = 7;

    // b^2 - 4c at full precision
    localparam int DISC_WIDTH = 2 * DIN_WIDTH + 1;
    localparam int DISC_POINT = 2 * DIN_POINT;

    localparam int BANDS = 4;

    // din_valid to fifo write
    localparam int FRONT_LATENCY = 3;

    localparam int ROOT_FIFO_DEPTH = 16;
    localparam int ROOT_FIFO_AW = 4;

    // one root bit per cycle
    localparam int SQRT_ITER = 9;

    typedef logic signed [DIN_WIDTH-1:0] coef_t;
    typedef logic signed [DISC_WIDTH-1:0] disc_t;
    typedef logic signed [SQRT_WIDTH-1:0] sqrt_t;
    typedef logic signed [SQRT_WIDTH-1:0] root_t;
    typedef logic [$clog2(BANDS)-1:0] band_t;

    typedef struct packed {
        coef_t b;
        coef_t c;
        band_t band;
    } coef_in_t;

    // fifo word
    typedef struct packed {
        sqrt_t disc;
        sqrt_t b_q;
        band_t band;
    } root_req_t;

    typedef struct packed {
        root_t x1;
        root_t x2;
        logic  error;
        band_t band;
    } root_res_t;

    typedef enum logic [1:0] {
        IDLE,
        POP,
        RUN,
        EMIT
    } solver_state_t;

endpackage

/* hw/root_fifo.sv */
`timescale 1ns/10ps

module root_fifo (
    input  logic                     clk,
    input  logic                     arst_n,
    input  quad_root_pkg::root_req_t wr_data,
    input  logic                     wr_en,
    output quad_root_pkg::root_req_t head,
    output logic                     not_empty,
    input  logic                     pop,
    output logic                     fifo_full
);

    import quad_root_pkg::*;

    root_req_t               mem [ROOT_FIFO_DEPTH];
    logic [ROOT_FIFO_AW-1:0] wr_ptr;
    logic [ROOT_FIFO_AW-1:0] rd_ptr;
    logic [ROOT_FIFO_AW:0]   count;
    logic                    do_wr;
    logic                    do_pop;

    // a write into a truly full buffer is dropped
    assign do_wr = wr_en && (count != (ROOT_FIFO_AW + 1)'(ROOT_FIFO_DEPTH));
    assign do_pop = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);

    // leave room for the samples still inside the front end
    assign fifo_full =
        (count >= (ROOT_FIFO_AW + 1)'(ROOT_FIFO_DEPTH - FRONT_LATENCY - 1));

endmodule

/* hw/root_solver.sv */
`timescale 1ns/10ps

module root_solver (
    input  logic                     clk,
    input  logic                     arst_n,
    input  quad_root_pkg::root_req_t head,
    input  logic                     not_empty,
    output logic                     pop,
    output quad_root_pkg::root_res_t dout,
    output logic                     dout_valid
);

    import quad_root_pkg::*;

    solver_state_t state;
    root_req_t     req_q;
    logic          start;
    logic          busy;
    logic          done;
    logic [SQRT_WIDTH-1:0] root;

    // two extra bits so -b +/- s never wraps
    logic signed [SQRT_WIDTH+1:0] b_neg;
    logic signed [SQRT_WIDTH+1:0] s_ext;
    logic signed [SQRT_WIDTH+1:0] sum_p;
    logic signed [SQRT_WIDTH+1:0] sum_m;

    assign pop = (state == POP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            start <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            start <= 1'b0;
            dout_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (not_empty) begin
                        state <= POP;
                    end
                end
                POP: begin
                    // negative discriminant skips the square root
                    if (head.disc[SQRT_WIDTH-1]) begin
                        state <= EMIT;
                    end else begin
                        start <= !busy;
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (done) begin
                        state <= EMIT;
                    end
                end
                EMIT: begin
                    dout_valid <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    iterative_sqrt sqrt0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .radicand(req_q.disc),
        .busy    (busy),
        .done    (done),
        .root    (root)
    );

    assign b_neg = -(SQRT_WIDTH + 2)'(req_q.b_q);
    assign s_ext = $signed({2'b00, root});
    assign sum_p = b_neg + s_ext;
    assign sum_m = b_neg - s_ext;

    always_ff @(posedge clk) begin
        if (state == POP) begin
            req_q <= head;
        end
        if (state == EMIT) begin
            dout.band <= req_q.band;
            dout.error <= req_q.disc[SQRT_WIDTH-1];
            if (req_q.disc[SQRT_WIDTH-1]) begin
                dout.x1 <= '0;
                dout.x2 <= '0;
            end else begin
                dout.x1 <= root_t'(sum_p >>> 1);
                dout.x2 <= root_t'(sum_m >>> 1);
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the quadratic root testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_quad_root \
        -f filelist.f --Mdir obj_dir -o sim_quad_root > build.log 2>&1; then
    cat build.log
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/sim_quad_root > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
